/* source/mem_map_pkg.sv */
// Address map for the line memory; only the row bits select a line, higher bits alias
package mem_map_pkg;

    // Width of raw addresses, offsets and the effective address
    localparam int addr_bits = 32;

    // Lines held by the line store
    localparam int line_count = 64;

    // Row index selects one line
    localparam int row_bits = $clog2(line_count);

    // Byte within a 512-bit line, not used by the line store
    localparam int offset_bits = 6;

    // Everything above row and offset is ignored
    localparam int high_bits = addr_bits - row_bits - offset_bits;

endpackage

/* source/mem_types_pkg.sv */
// Operation codes, bus width and address layout; op value 3 is reserved and acts as idle
package mem_types_pkg;

    // Operation field presented by each requester
    localparam int op_bits = 2;

    localparam logic [op_bits-1:0] op_idle  = 2'd0;
    localparam logic [op_bits-1:0] op_read  = 2'd1;
    localparam logic [op_bits-1:0] op_write = 2'd2;

    // One memory line, also the width of both data buses
    localparam int line_bits = 512;

    // Field view of an effective address
    typedef struct packed {
        logic [mem_map_pkg::high_bits-1:0]   high;
        logic [mem_map_pkg::row_bits-1:0]    row;
        logic [mem_map_pkg::offset_bits-1:0] byte_offset;
    } mem_addr_fields_t;

    // Sum of raw address and offset, read back as fields to pick the row
    typedef union packed {
        logic [mem_map_pkg::addr_bits-1:0] flat;
        mem_addr_fields_t                  fields;
    } mem_addr_u;

endpackage

/* source/mem_arbiter.sv */
// Two-source arbiter; a grant is held until tx_done, ties alternate starting with source 1
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                                   clk,
    input  logic                                   rst_n,
    // Source 1 requests
    input  logic [mem_types_pkg::op_bits-1:0]      op_src1,
    input  logic [mem_map_pkg::addr_bits-1:0]      raw_address_src1,
    input  logic [mem_map_pkg::addr_bits-1:0]      address_offset_src1,
    input  logic [mem_types_pkg::line_bits-1:0]    common_data_bus_read_in_src1,
    output logic [mem_types_pkg::line_bits-1:0]    common_data_bus_write_out_src1,
    output logic                                   tx_done_src1,
    output logic                                   rd_valid_src1,
    // Source 2 requests
    input  logic [mem_types_pkg::op_bits-1:0]      op_src2,
    input  logic [mem_map_pkg::addr_bits-1:0]      raw_address_src2,
    input  logic [mem_map_pkg::addr_bits-1:0]      address_offset_src2,
    input  logic [mem_types_pkg::line_bits-1:0]    common_data_bus_read_in_src2,
    output logic [mem_types_pkg::line_bits-1:0]    common_data_bus_write_out_src2,
    output logic                                   tx_done_src2,
    output logic                                   rd_valid_src2,
    // Returned from the controller
    input  logic [mem_types_pkg::line_bits-1:0]    common_data_bus_write_out,
    input  logic                                   tx_done,
    input  logic                                   rd_valid,
    // Toward the controller, named from its side
    output logic [mem_types_pkg::op_bits-1:0]      op,
    output logic [mem_map_pkg::addr_bits-1:0]      raw_address,
    output logic [mem_map_pkg::addr_bits-1:0]      address_offset,
    output logic [mem_types_pkg::line_bits-1:0]    common_data_bus_read_in
);

    typedef enum logic [1:0] {READY, SRC1, SRC2} arb_state_t;

    arb_state_t current, next;
    logic       last_served_src2;
    logic       req_src1;
    logic       req_src2;

    // Only read and write count as requests
    assign req_src1 = (op_src1 == mem_types_pkg::op_read) || (op_src1 == mem_types_pkg::op_write);
    assign req_src2 = (op_src2 == mem_types_pkg::op_read) || (op_src2 == mem_types_pkg::op_write);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            current          <= READY;
            last_served_src2 <= 1'b1;
        end else begin
            current <= next;
            // Remember who was granted for the next tie
            if (current == READY && next == SRC1) begin
                last_served_src2 <= 1'b0;
            end else if (current == READY && next == SRC2) begin
                last_served_src2 <= 1'b1;
            end
        end
    end

    always_comb begin
        // Idle bus and quiet sources unless granted
        op                             = mem_types_pkg::op_idle;
        raw_address                    = '0;
        address_offset                 = '0;
        common_data_bus_read_in        = '0;
        common_data_bus_write_out_src1 = '0;
        tx_done_src1                   = 1'b0;
        rd_valid_src1                  = 1'b0;
        common_data_bus_write_out_src2 = '0;
        tx_done_src2                   = 1'b0;
        rd_valid_src2                  = 1'b0;
        next                           = current;

        case (current)
            READY: begin
                if (req_src1 && req_src2) begin
                    next = last_served_src2 ? SRC1 : SRC2;
                end else if (req_src1) begin
                    next = SRC1;
                end else if (req_src2) begin
                    next = SRC2;
                end
            end
            SRC1: begin
                op                             = op_src1;
                raw_address                    = raw_address_src1;
                address_offset                 = address_offset_src1;
                common_data_bus_read_in        = common_data_bus_read_in_src1;
                common_data_bus_write_out_src1 = common_data_bus_write_out;
                tx_done_src1                   = tx_done;
                rd_valid_src1                  = rd_valid;
                if (tx_done) begin
                    next = READY;
                end
            end
            SRC2: begin
                op                             = op_src2;
                raw_address                    = raw_address_src2;
                address_offset                 = address_offset_src2;
                common_data_bus_read_in        = common_data_bus_read_in_src2;
                common_data_bus_write_out_src2 = common_data_bus_write_out;
                tx_done_src2                   = tx_done;
                rd_valid_src2                  = rd_valid;
                if (tx_done) begin
                    next = READY;
                end
            end
            default: begin
                next = READY;
            end
        endcase
    end

endmodule

/* source/mem_addr_stage.sv */
// Address stage; launches one access per held op and waits for tx_done before the next
`timescale 1ns/1ps

module mem_addr_stage (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [mem_types_pkg::op_bits-1:0]      op,
    input  logic [mem_map_pkg::addr_bits-1:0]      raw_address,
    input  logic [mem_map_pkg::addr_bits-1:0]      address_offset,
    input  logic [mem_types_pkg::line_bits-1:0]    common_data_bus_read_in,
    input  logic                                   tx_done,
    output logic                                   access_start,
    output logic                                   access_write,
    output logic [mem_map_pkg::row_bits-1:0]       access_row,
    output logic [mem_types_pkg::line_bits-1:0]    access_data
);

    mem_types_pkg::mem_addr_u eff_addr;
    logic                     busy;
    logic                     op_valid;
    logic                     launch;

    // Effective address, then only the row field matters
    assign eff_addr.flat = raw_address + address_offset;

    assign op_valid = (op == mem_types_pkg::op_read) || (op == mem_types_pkg::op_write);
    assign launch   = op_valid && !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy         <= 1'b0;
            access_start <= 1'b0;
            access_write <= 1'b0;
            access_row   <= '0;
            access_data  <= '0;
        end else begin
            access_start <= launch;
            if (launch) begin
                busy         <= 1'b1;
                access_write <= (op == mem_types_pkg::op_write);
                access_row   <= eff_addr.fields.row;
                access_data  <= common_data_bus_read_in;
            end else if (tx_done) begin
                // Op is still held during done, so the clear waits for it
                busy <= 1'b0;
            end
        end
    end

endmodule

/* source/mem_line_store.sv */
// 64 x 512-bit line store; contents are not reset, one access at a time, done one cycle later
`timescale 1ns/1ps

module mem_line_store (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   access_start,
    input  logic                                   access_write,
    input  logic [mem_map_pkg::row_bits-1:0]       access_row,
    input  logic [mem_types_pkg::line_bits-1:0]    access_data,
    output logic                                   tx_done,
    output logic                                   rd_valid,
    output logic [mem_types_pkg::line_bits-1:0]    common_data_bus_write_out
);

    logic [mem_types_pkg::line_bits-1:0] lines [mem_map_pkg::line_count];

    // Line array
    always_ff @(posedge clk) begin
        if (access_start && access_write) begin
            lines[access_row] <= access_data;
        end
    end

    // Done pulse and read return
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_done                   <= 1'b0;
            rd_valid                  <= 1'b0;
            common_data_bus_write_out <= '0;
        end else begin
            tx_done  <= access_start;
            rd_valid <= access_start && !access_write;
            if (access_start && !access_write) begin
                common_data_bus_write_out <= lines[access_row];
            end
        end
    end

endmodule

/* source/mem_subsystem.sv */
// Shared line memory for two requesters; each holds its op until its own tx_done pulse
`timescale 1ns/1ps

module mem_subsystem (
    input  logic                                   clk,
    input  logic                                   rst_n,
    // Source 1
    input  logic [mem_types_pkg::op_bits-1:0]      op_src1,
    input  logic [mem_map_pkg::addr_bits-1:0]      raw_address_src1,
    input  logic [mem_map_pkg::addr_bits-1:0]      address_offset_src1,
    input  logic [mem_types_pkg::line_bits-1:0]    common_data_bus_read_in_src1,
    output logic [mem_types_pkg::line_bits-1:0]    common_data_bus_write_out_src1,
    output logic                                   tx_done_src1,
    output logic                                   rd_valid_src1,
    // Source 2
    input  logic [mem_types_pkg::op_bits-1:0]      op_src2,
    input  logic [mem_map_pkg::addr_bits-1:0]      raw_address_src2,
    input  logic [mem_map_pkg::addr_bits-1:0]      address_offset_src2,
    input  logic [mem_types_pkg::line_bits-1:0]    common_data_bus_read_in_src2,
    output logic [mem_types_pkg::line_bits-1:0]    common_data_bus_write_out_src2,
    output logic                                   tx_done_src2,
    output logic                                   rd_valid_src2
);

    // Arbiter to address stage
    logic [mem_types_pkg::op_bits-1:0]   op;
    logic [mem_map_pkg::addr_bits-1:0]   raw_address;
    logic [mem_map_pkg::addr_bits-1:0]   address_offset;
    logic [mem_types_pkg::line_bits-1:0] common_data_bus_read_in;

    // Address stage to line store
    logic                                access_start;
    logic                                access_write;
    logic [mem_map_pkg::row_bits-1:0]    access_row;
    logic [mem_types_pkg::line_bits-1:0] access_data;

    // Line store back to arbiter
    logic                                tx_done;
    logic                                rd_valid;
    logic [mem_types_pkg::line_bits-1:0] common_data_bus_write_out;

    mem_arbiter i_mem_arbiter (
        .clk                            (clk),
        .rst_n                          (rst_n),
        .op_src1                        (op_src1),
        .raw_address_src1               (raw_address_src1),
        .address_offset_src1            (address_offset_src1),
        .common_data_bus_read_in_src1   (common_data_bus_read_in_src1),
        .common_data_bus_write_out_src1 (common_data_bus_write_out_src1),
        .tx_done_src1                   (tx_done_src1),
        .rd_valid_src1                  (rd_valid_src1),
        .op_src2                        (op_src2),
        .raw_address_src2               (raw_address_src2),
        .address_offset_src2            (address_offset_src2),
        .common_data_bus_read_in_src2   (common_data_bus_read_in_src2),
        .common_data_bus_write_out_src2 (common_data_bus_write_out_src2),
        .tx_done_src2                   (tx_done_src2),
        .rd_valid_src2                  (rd_valid_src2),
        .common_data_bus_write_out      (common_data_bus_write_out),
        .tx_done                        (tx_done),
        .rd_valid                       (rd_valid),
        .op                             (op),
        .raw_address                    (raw_address),
        .address_offset                 (address_offset),
        .common_data_bus_read_in        (common_data_bus_read_in)
    );

    mem_addr_stage i_mem_addr_stage (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .op                      (op),
        .raw_address             (raw_address),
        .address_offset          (address_offset),
        .common_data_bus_read_in (common_data_bus_read_in),
        .tx_done                 (tx_done),
        .access_start            (access_start),
        .access_write            (access_write),
        .access_row              (access_row),
        .access_data             (access_data)
    );

    mem_line_store i_mem_line_store (
        .clk                       (clk),
        .rst_n                     (rst_n),
        .access_start              (access_start),
        .access_write              (access_write),
        .access_row                (access_row),
        .access_data               (access_data),
        .tx_done                   (tx_done),
        .rd_valid                  (rd_valid),
        .common_data_bus_write_out (common_data_bus_write_out)
    );

endmodule

/* test/tb_clock_gen.sv */
// Free-running 8 ns clock; rst_n is held low for the first two rising edges only
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam realtime half_period = 4ns;

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

    always #(half_period) clk = ~clk;

endmodule

/* test/mem_checker.sv */
// Reference model of the line memory; expects the table to read only rows it has written
`timescale 1ns/1ps

module mem_checker (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [1:0]   op_src1,
    input  logic [31:0]  raw_address_src1,
    input  logic [31:0]  address_offset_src1,
    input  logic [511:0] common_data_bus_read_in_src1,
    input  logic [511:0] common_data_bus_write_out_src1,
    input  logic         tx_done_src1,
    input  logic         rd_valid_src1,
    input  logic [1:0]   op_src2,
    input  logic [31:0]  raw_address_src2,
    input  logic [31:0]  address_offset_src2,
    input  logic [511:0] common_data_bus_read_in_src2,
    input  logic [511:0] common_data_bus_write_out_src2,
    input  logic         tx_done_src2,
    input  logic         rd_valid_src2,
    output int           pass_count,
    output int           error_count,
    output int           outstanding
);

    // Row sits just above the 64-byte line offset
    localparam int row_shift   = 6;
    localparam int lone_cycles = 3;
    localparam int gap_cycles  = 4;

    logic [511:0] model [64];
    logic         model_valid [64];
    logic         pending [1:2];
    int           expect_cycle [1:2];
    int           cycle;
    int           last_served;
    int           test_num;
    logic [1:0]   prev_op1;
    logic [1:0]   prev_op2;
    logic         start1;
    logic         start2;

    function automatic int row_of(input logic [31:0] raw, input logic [31:0] off);
        logic [31:0] sum;
        sum = raw + off;
        return int'(sum[row_shift +: 6]);
    endfunction

    task automatic handle_done(input int src, input logic [1:0] op, input logic [31:0] raw,
                               input logic [31:0] off, input logic [511:0] wdata,
                               input logic [511:0] rdata, input logic rvalid,
                               input logic [511:0] other_data, input logic other_valid);
        int   row;
        int   errs_before;
        logic is_write;
        errs_before = error_count;
        row         = row_of(raw, off);
        is_write    = (op == mem_types_pkg::op_write);
        if (!pending[src]) begin
            $display("Unexpected done pulse on source %0d at time %0t", src, $time);
            error_count++;
            return;
        end
        if (cycle != expect_cycle[src]) begin
            $display("Mismatch at %0t: source %0d done in cycle %0d, expected cycle %0d",
                     $time, src, cycle, expect_cycle[src]);
            error_count++;
        end
        if (rvalid != !is_write) begin
            $display("Mismatch at %0t: source %0d rd_valid is %0b", $time, src, rvalid);
            error_count++;
        end
        // The idle source must stay silent
        if (other_data != '0 || other_valid) begin
            $display("Mismatch at %0t: outputs of the other source not zero", $time);
            error_count++;
        end
        if (is_write) begin
            model[row]       = wdata;
            model_valid[row] = 1'b1;
        end else if (!model_valid[row]) begin
            $display("Read of row %0d by source %0d before any write to it", row, src);
            error_count++;
        end else if (rdata != model[row]) begin
            $display("Mismatch at %0t: source %0d read row %0d, data differs from model",
                     $time, src, row);
            error_count++;
        end
        pending[src] = 1'b0;
        last_served  = src;
        test_num++;
        if (error_count == errs_before) begin
            pass_count++;
        end
        $display("Test %0d: source %0d %s row %0d %s", test_num, src,
                 is_write ? "write" : "read", row,
                 (error_count == errs_before) ? "ok" : "FAILED");
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle        = 0;
            last_served  = 2;
            test_num     = 0;
            pass_count   = 0;
            error_count  = 0;
            pending[1]   = 1'b0;
            pending[2]   = 1'b0;
            prev_op1     = mem_types_pkg::op_idle;
            prev_op2     = mem_types_pkg::op_idle;
            for (int i = 0; i < 64; i++) begin
                model_valid[i] = 1'b0;
            end
        end else begin
            cycle++;
            if (tx_done_src1) begin
                handle_done(1, op_src1, raw_address_src1, address_offset_src1,
                            common_data_bus_read_in_src1, common_data_bus_write_out_src1,
                            rd_valid_src1, common_data_bus_write_out_src2, rd_valid_src2);
            end
            if (tx_done_src2) begin
                handle_done(2, op_src2, raw_address_src2, address_offset_src2,
                            common_data_bus_read_in_src2, common_data_bus_write_out_src2,
                            rd_valid_src2, common_data_bus_write_out_src1, rd_valid_src1);
            end
            start1 = (op_src1 != mem_types_pkg::op_idle) && (prev_op1 == mem_types_pkg::op_idle);
            start2 = (op_src2 != mem_types_pkg::op_idle) && (prev_op2 == mem_types_pkg::op_idle);
            if (start1 && start2) begin
                // Tie goes to the source not served last
                if (last_served == 2) begin
                    expect_cycle[1] = cycle + lone_cycles;
                    expect_cycle[2] = cycle + lone_cycles + gap_cycles;
                end else begin
                    expect_cycle[2] = cycle + lone_cycles;
                    expect_cycle[1] = cycle + lone_cycles + gap_cycles;
                end
                pending[1] = 1'b1;
                pending[2] = 1'b1;
            end else if (start1) begin
                expect_cycle[1] = pending[2] ? expect_cycle[2] + gap_cycles : cycle + lone_cycles;
                pending[1]      = 1'b1;
            end else if (start2) begin
                expect_cycle[2] = pending[1] ? expect_cycle[1] + gap_cycles : cycle + lone_cycles;
                pending[2]      = 1'b1;
            end
            prev_op1 = op_src1;
            prev_op2 = op_src2;
        end
        outstanding = int'(pending[1]) + int'(pending[2]);
    end

endmodule

/* test/mem_subsystem_assertions.sv */
// Bound into mem_subsystem; checks done pulse shape and that one access runs at a time
`timescale 1ns/1ps

module mem_subsystem_assertions (
    input logic       clk,
    input logic       rst_n,
    input logic [1:0] op_src1,
    input logic [1:0] op_src2,
    input logic       tx_done_src1,
    input logic       tx_done_src2,
    input logic       rd_valid_src1,
    input logic       rd_valid_src2,
    input logic       access_start,
    input logic       tx_done
);

    done_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(tx_done_src1 && tx_done_src2))
        else $error("tx_done raised on both sources");

    done1_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        tx_done_src1 |=> !tx_done_src1)
        else $error("tx_done_src1 longer than one cycle");

    done2_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        tx_done_src2 |=> !tx_done_src2)
        else $error("tx_done_src2 longer than one cycle");

    valid1_with_done: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid_src1 |-> tx_done_src1)
        else $error("rd_valid_src1 without tx_done_src1");

    valid2_with_done: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid_src2 |-> tx_done_src2)
        else $error("rd_valid_src2 without tx_done_src2");

    done1_requested: assert property (@(posedge clk) disable iff (!rst_n)
        tx_done_src1 |-> (op_src1 != 2'd0))
        else $error("tx_done_src1 while source 1 is idle");

    done2_requested: assert property (@(posedge clk) disable iff (!rst_n)
        tx_done_src2 |-> (op_src2 != 2'd0))
        else $error("tx_done_src2 while source 2 is idle");

    // A launch is followed by its done, never by a second launch
    start_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        access_start |=> (tx_done && !access_start))
        else $error("access_start while an access is in flight");

endmodule

bind mem_subsystem mem_subsystem_assertions i_mem_subsystem_assertions (.*);

/* test/mem_subsystem_tb.sv */
// Table-driven testbench; every read row targets a row written earlier in the table
`timescale 1ns/1ps

module mem_subsystem_tb;

    localparam int row_count      = 12;
    localparam int timeout_cycles = row_count * 8 + 50;

    logic                                   clk;
    logic                                   rst_n;
    logic [1:0]                             op_src1;
    logic [mem_map_pkg::addr_bits-1:0]      raw_address_src1;
    logic [mem_map_pkg::addr_bits-1:0]      address_offset_src1;
    logic [mem_types_pkg::line_bits-1:0]    common_data_bus_read_in_src1;
    logic [mem_types_pkg::line_bits-1:0]    common_data_bus_write_out_src1;
    logic                                   tx_done_src1;
    logic                                   rd_valid_src1;
    logic [1:0]                             op_src2;
    logic [mem_map_pkg::addr_bits-1:0]      raw_address_src2;
    logic [mem_map_pkg::addr_bits-1:0]      address_offset_src2;
    logic [mem_types_pkg::line_bits-1:0]    common_data_bus_read_in_src2;
    logic [mem_types_pkg::line_bits-1:0]    common_data_bus_write_out_src2;
    logic                                   tx_done_src2;
    logic                                   rd_valid_src2;
    int                                     pass_count;
    int                                     error_count;
    int                                     outstanding;
    int                                     cycle_count;
    logic                                   active1;
    logic                                   active2;

    // Stimulus table, one entry per source and row
    logic [1:0]  tbl_op1 [row_count];
    logic [31:0] tbl_raw1 [row_count];
    logic [31:0] tbl_off1 [row_count];
    logic [1:0]  tbl_op2 [row_count];
    logic [31:0] tbl_raw2 [row_count];
    logic [31:0] tbl_off2 [row_count];

    tb_clock_gen i_tb_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_subsystem i_mem_subsystem (.*);

    mem_checker i_mem_checker (.*);

    task automatic set_row(input int r, input logic [1:0] op1, input logic [31:0] raw1,
                           input logic [31:0] off1, input logic [1:0] op2,
                           input logic [31:0] raw2, input logic [31:0] off2);
        tbl_op1[r]  = op1;
        tbl_raw1[r] = raw1;
        tbl_off1[r] = off1;
        tbl_op2[r]  = op2;
        tbl_raw2[r] = raw2;
        tbl_off2[r] = off2;
    endtask

    task automatic fill_table();
        logic [1:0] idle;
        logic [1:0] rd;
        logic [1:0] wr;
        idle = mem_types_pkg::op_idle;
        rd   = mem_types_pkg::op_read;
        wr   = mem_types_pkg::op_write;
        // Write then read back on source 1
        set_row(0, wr, 32'h0000_0140, 32'h0, idle, 32'h0, 32'h0);
        set_row(1, rd, 32'h0000_0140, 32'h0, idle, 32'h0, 32'h0);
        // Offset folded into the row, byte bits ignored
        set_row(2, wr, 32'h0000_0200, 32'h85, idle, 32'h0, 32'h0);
        set_row(3, rd, 32'h0000_0285, 32'h0, idle, 32'h0, 32'h0);
        // Ties, order alternates
        set_row(4, wr, 32'h0000_0400, 32'h0, wr, 32'h0000_0440, 32'h0);
        set_row(5, rd, 32'h0000_0440, 32'h0, rd, 32'h0000_0400, 32'h0);
        set_row(6, rd, 32'h0000_0400, 32'h0, rd, 32'h0000_0440, 32'h0);
        // High address from source 2
        set_row(7, idle, 32'h0, 32'h0, wr, 32'hABC0_0800, 32'h0);
        set_row(8, idle, 32'h0, 32'h0, rd, 32'h0000_0140, 32'h0);
        // Aliased read from source 1, so source 2 wins the next tie
        set_row(9, rd, 32'h0000_0800, 32'h0, idle, 32'h0, 32'h0);
        set_row(10, wr, 32'h0000_07C0, 32'h0, wr, 32'h0000_0FC0, 32'h0);
        set_row(11, rd, 32'h0000_0FC0, 32'h0, rd, 32'h0000_07C0, 32'h0);
    endtask

    function automatic logic [mem_types_pkg::line_bits-1:0] random_line();
        logic [mem_types_pkg::line_bits-1:0] data;
        for (int i = 0; i < mem_types_pkg::line_bits / 32; i++) begin
            data[i*32 +: 32] = $urandom;
        end
        return data;
    endfunction

    initial begin
        op_src1                      = mem_types_pkg::op_idle;
        raw_address_src1             = '0;
        address_offset_src1          = '0;
        common_data_bus_read_in_src1 = '0;
        op_src2                      = mem_types_pkg::op_idle;
        raw_address_src2             = '0;
        address_offset_src2          = '0;
        common_data_bus_read_in_src2 = '0;
        void'($urandom(32'h1d08_f33e));
        fill_table();
        @(posedge rst_n);
        for (int r = 0; r < row_count; r++) begin
            @(posedge clk);
            op_src1                      <= tbl_op1[r];
            raw_address_src1             <= tbl_raw1[r];
            address_offset_src1          <= tbl_off1[r];
            common_data_bus_read_in_src1 <= random_line();
            op_src2                      <= tbl_op2[r];
            raw_address_src2             <= tbl_raw2[r];
            address_offset_src2          <= tbl_off2[r];
            common_data_bus_read_in_src2 <= random_line();
            active1 = (tbl_op1[r] != mem_types_pkg::op_idle);
            active2 = (tbl_op2[r] != mem_types_pkg::op_idle);
            while (active1 || active2) begin
                @(posedge clk);
                // Drop op on the edge that ends the done pulse
                if (active1 && tx_done_src1) begin
                    op_src1 <= mem_types_pkg::op_idle;
                    active1 = 1'b0;
                end
                if (active2 && tx_done_src2) begin
                    op_src2 <= mem_types_pkg::op_idle;
                    active2 = 1'b0;
                end
            end
        end
        repeat (2) @(posedge clk);
        $display("Finished: %0d tests passed, %0d errors, %0d without done",
                 pass_count, error_count, outstanding);
        if (error_count == 0 && outstanding == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Run length guard
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= timeout_cycles) begin
                $display("Timeout after %0d cycles, a done pulse never came", cycle_count);
                $display("CHECKS FAILED");
                $finish;
            end
        end
    end

endmodule

/* compile.f */
source/mem_map_pkg.sv
source/mem_types_pkg.sv
source/mem_arbiter.sv
source/mem_addr_stage.sv
source/mem_line_store.sv
source/mem_subsystem.sv
test/tb_clock_gen.sv
test/mem_checker.sv
test/mem_subsystem_assertions.sv
test/mem_subsystem_tb.sv

/* run_sim.sh */
#!/bin/bash
# Build with Verilator, run, and pass only if the pass message is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module mem_subsystem_tb -Mdir obj_dir || exit 1
out="$(./obj_dir/Vmem_subsystem_tb)"
echo "$out"
echo "$out" | grep -q "ALL CHECKS PASSED" && echo "Simulation passed" || {
    echo "Simulation failed"
    exit 1
}
